// File: design/rom_sys_config.svh
// Include in each file that needs it; the widths assume four slots with the two wide slots first
`ifndef ROM_SYS_CONFIG_SVH
`define ROM_SYS_CONFIG_SVH

// SDRAM word address and download byte address
`define ROM_AW      22
`define DL_AW       23

// Read slots, addressed in slot units
`define SLOT_AW     17
`define NSLOTS      4

// Leading download bytes kept out of SDRAM
`define HDR_LEN     4

// Byte addresses of the AXI4-Lite registers
`define AXI_AW      8
`define REG_CTRL    'h00
`define REG_STATUS  'h04
`define REG_GAMECFG 'h08
`define REG_OFS0    'h10

`endif

// File: design/rom_sys_pkg.sv
// Types shared by RTL and testbench; a narrow slot reads one byte lane of an SDRAM word
`default_nettype none

package rom_sys_pkg;

    // Byte lanes of one SDRAM word
    typedef struct packed {
        logic [7:0] hi;
        logic [7:0] lo;
    } sdram_lanes_t;

    // Whole word for wide slots, lanes for narrow ones
    typedef union packed {
        logic [15:0]  word;
        sdram_lanes_t lane;
    } sdram_word_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_t;

endpackage

`default_nettype wire

// File: design/rom_dl_writer.sv
// prog_mask is active high per lane; the source must wait for sdram_ack before the next ioctl_wr
`timescale 1ns/1ps
`default_nettype none
`include "rom_sys_config.svh"

module rom_dl_writer (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 downloading,
    input  wire  [`DL_AW-1:0]   ioctl_addr,
    input  wire  [7:0]          ioctl_dout,
    input  wire                 ioctl_wr,
    input  wire                 sdram_ack,
    output logic [`ROM_AW-1:0]  prog_addr,
    output logic [7:0]          prog_data,
    output logic [1:0]          prog_mask,
    output logic                prog_we,
    output logic [7:0]          game_cfg,
    output logic                hdr_valid
);

    logic [`DL_AW-1:0] rel_addr;    // Byte address past the header
    logic              byte_wr;
    logic              is_hdr;
    logic              dl_l;        // Delayed downloading for edge detect

    assign byte_wr  = downloading && ioctl_wr;
    assign is_hdr   = ioctl_addr < `DL_AW'(`HDR_LEN);
    assign rel_addr = ioctl_addr - `DL_AW'(`HDR_LEN);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prog_we   <= 1'b0;
            game_cfg  <= 8'h00;
            hdr_valid <= 1'b0;
            dl_l      <= 1'b0;
        end else begin
            dl_l <= downloading;
            if (downloading && !dl_l)
                hdr_valid <= 1'b0;              // New ROM set coming
            if (prog_we && sdram_ack)
                prog_we <= 1'b0;
            if (byte_wr) begin
                if (!is_hdr)
                    prog_we <= 1'b1;
                else if (ioctl_addr == '0)
                    game_cfg <= ioctl_dout;     // First header byte only
                if (ioctl_addr == `DL_AW'(`HDR_LEN - 1))
                    hdr_valid <= 1'b1;
            end
        end
    end

    // Held until the controller takes it
    always_ff @(posedge clk) begin
        if (byte_wr && !is_hdr) begin
            prog_addr <= rel_addr[`ROM_AW:1];
            prog_data <= ioctl_dout;
            prog_mask <= rel_addr[0] ? 2'b10 : 2'b01;   // Odd bytes to the high lane
        end
    end

endmodule

`default_nettype wire

// File: design/rom_slot_arb.sv
// Slots 0-1 are 16-bit and 2-3 are 8-bit; data_rdy must come after sdram_ack, one read in flight
`timescale 1ns/1ps
`default_nettype none
`include "rom_sys_config.svh"

module rom_slot_arb (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          downloading,
    input  wire  [`NSLOTS-1:0]           slot_en,
    input  wire  [`NSLOTS*`ROM_AW-1:0]   slot_ofs,
    input  wire  [`NSLOTS-1:0]           slot_cs,
    input  wire  [`NSLOTS*`SLOT_AW-1:0]  slot_addr,
    output wire  [`NSLOTS*16-1:0]        slot_dout,
    output wire  [`NSLOTS-1:0]           slot_ok,
    output logic                         sdram_req,
    output logic [`ROM_AW-1:0]           sdram_addr,
    input  wire                          sdram_ack,
    input  wire                          data_rdy,
    input  wire  [15:0]                  data_read
);

    import rom_sys_pkg::*;

    localparam int SW    = $clog2(`NSLOTS);
    localparam int NWIDE = 2;                   // Slots below this index are 16-bit

    wire  [`ROM_AW-1:0] word_addr [`NSLOTS];
    wire  [`NSLOTS-1:0] need;
    wire  [`NSLOTS-1:0] fill;
    logic [SW-1:0]      cur;                    // Slot in flight or last served
    logic [SW-1:0]      gnt;
    logic               gnt_any;
    logic               pend;                   // Acked, waiting for data_rdy
    logic               start;

    for (genvar i = 0; i < `NSLOTS; i++) begin : g_slot
        localparam bit WIDE = i < NWIDE;

        logic [`ROM_AW-1:0]  ofs;
        logic [`SLOT_AW-1:0] addr;
        logic                hit;
        logic                hit_nx;
        logic                cvalid;
        logic [`ROM_AW-1:0]  tag;
        sdram_word_t         cdata;
        sdram_word_t         src;
        logic                ok_q;
        logic [15:0]         dout_q;

        assign ofs  = slot_ofs[i*`ROM_AW +: `ROM_AW];
        assign addr = slot_addr[i*`SLOT_AW +: `SLOT_AW];

        // Narrow slots pack two bytes per word
        assign word_addr[i] = ofs + (WIDE ? `ROM_AW'(addr) : `ROM_AW'(addr >> 1));

        assign hit     = cvalid && tag == word_addr[i];
        assign need[i] = slot_en[i] && slot_cs[i] && !hit;
        assign fill[i] = pend && data_rdy && cur == SW'(i);
        assign hit_nx  = hit || (fill[i] && sdram_addr == word_addr[i]);
        assign src.word = fill[i] ? data_read : cdata.word;   // Bypass on fill

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                cvalid <= 1'b0;
                ok_q   <= 1'b0;
            end else begin
                ok_q <= slot_en[i] && slot_cs[i] && hit_nx;
                if (downloading)
                    cvalid <= 1'b0;             // ROM contents are changing
                else if (fill[i])
                    cvalid <= 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (fill[i]) begin
                tag   <= sdram_addr;
                cdata <= src;
            end
            if (WIDE)
                dout_q <= src.word;
            else
                dout_q <= {8'h00, addr[0] ? src.lane.hi : src.lane.lo};
        end

        assign slot_ok[i]            = ok_q;
        assign slot_dout[i*16 +: 16] = dout_q;
    end

    // Round robin, search starts after the last slot served
    always_comb begin
        logic [SW-1:0] idx;
        gnt_any = 1'b0;
        gnt     = cur;
        for (int k = 1; k <= `NSLOTS; k++) begin
            idx = cur + SW'(k);
            if (!gnt_any && need[idx]) begin
                gnt_any = 1'b1;
                gnt     = idx;
            end
        end
    end

    assign start = !sdram_req && !pend && gnt_any && !downloading;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sdram_req <= 1'b0;
            pend      <= 1'b0;
            cur       <= SW'(`NSLOTS - 1);      // Slot 0 goes first
        end else begin
            if (start) begin
                sdram_req <= 1'b1;
                cur       <= gnt;
            end
            if (sdram_req && sdram_ack) begin
                sdram_req <= 1'b0;
                pend      <= 1'b1;
            end
            if (pend && data_rdy)
                pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start)
            sdram_addr <= word_addr[gnt];
    end

endmodule

`default_nettype wire

// File: design/rom_cfg_regs.sv
// AXI4-Lite slave with a 32-bit data bus; a write needs address and data valid together
`timescale 1ns/1ps
`default_nettype none
`include "rom_sys_config.svh"

module rom_cfg_regs (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire  [`AXI_AW-1:0]            awaddr,
    input  wire                           awvalid,
    output logic                          awready,
    input  wire  [31:0]                   wdata,
    input  wire  [3:0]                    wstrb,
    input  wire                           wvalid,
    output logic                          wready,
    output rom_sys_pkg::axi_resp_t        bresp,
    output logic                          bvalid,
    input  wire                           bready,
    input  wire  [`AXI_AW-1:0]            araddr,
    input  wire                           arvalid,
    output logic                          arready,
    output logic [31:0]                   rdata,
    output rom_sys_pkg::axi_resp_t        rresp,
    output logic                          rvalid,
    input  wire                           rready,
    input  wire                           downloading,
    input  wire                           hdr_valid,
    input  wire  [7:0]                    game_cfg,
    output logic [`NSLOTS-1:0]            slot_en,
    output logic [`NSLOTS*`ROM_AW-1:0]    slot_ofs
);

    import rom_sys_pkg::*;

    localparam int SW = $clog2(`NSLOTS);

    logic [`NSLOTS-1:0] ctrl;
    logic [`ROM_AW-1:0] ofs [`NSLOTS];
    logic               wr_go, wr_hs, wr_ok;
    logic               ar_go, ar_hs, rd_ok;
    logic [31:0]        wr_old, wr_val, rd_val;
    int                 aw_sel, ar_sel;

    // Index of the offset register at this address, -1 if none
    function automatic int ofs_index(input logic [`AXI_AW-1:0] a);
        int idx;
        idx = -1;
        for (int i = 0; i < `NSLOTS; i++)
            if (a == `AXI_AW'(`REG_OFS0 + 4 * i))
                idx = i;
        return idx;
    endfunction

    function automatic logic [31:0] apply_strb(input logic [31:0] old, input logic [31:0] d,
                                               input logic [3:0] strb);
        logic [31:0] res;
        for (int b = 0; b < 4; b++)
            res[8*b +: 8] = strb[b] ? d[8*b +: 8] : old[8*b +: 8];
        return res;
    endfunction

    assign aw_sel = ofs_index(awaddr);
    assign ar_sel = ofs_index(araddr);
    assign wr_ok  = awaddr == `AXI_AW'(`REG_CTRL) || aw_sel >= 0;
    assign wr_old = awaddr == `AXI_AW'(`REG_CTRL) ? 32'(ctrl) : 32'(ofs[aw_sel[SW-1:0]]);
    assign wr_val = apply_strb(wr_old, wdata, wstrb);

    // Ready pulses one cycle after valid, blocked while a response waits
    assign wr_go = awvalid && wvalid && !awready && !bvalid;
    assign wr_hs = awready && awvalid && wvalid;
    assign ar_go = arvalid && !arready && !rvalid;
    assign ar_hs = arready && arvalid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= OKAY;
            ctrl    <= '0;
            for (int i = 0; i < `NSLOTS; i++)
                ofs[i] <= '0;
        end else begin
            awready <= wr_go;
            wready  <= wr_go;
            if (wr_hs) begin
                bvalid <= 1'b1;
                bresp  <= wr_ok ? OKAY : SLVERR;
                if (awaddr == `AXI_AW'(`REG_CTRL))
                    ctrl <= wr_val[`NSLOTS-1:0];
                else if (aw_sel >= 0)
                    ofs[aw_sel[SW-1:0]] <= wr_val[`ROM_AW-1:0];
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_comb begin
        rd_val = 32'h0;
        rd_ok  = 1'b1;
        if (araddr == `AXI_AW'(`REG_CTRL))
            rd_val = 32'(ctrl);
        else if (araddr == `AXI_AW'(`REG_STATUS))
            rd_val = {30'h0, hdr_valid, downloading};
        else if (araddr == `AXI_AW'(`REG_GAMECFG))
            rd_val = {24'h0, game_cfg};
        else if (ar_sel >= 0)
            rd_val = 32'(ofs[ar_sel[SW-1:0]]);
        else
            rd_ok = 1'b0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rresp   <= OKAY;
        end else begin
            arready <= ar_go;
            if (ar_hs) begin
                rvalid <= 1'b1;
                rresp  <= rd_ok ? OKAY : SLVERR;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs)
            rdata <= rd_val;
    end

    assign slot_en = ctrl;
    for (genvar i = 0; i < `NSLOTS; i++) begin : g_ofs
        assign slot_ofs[i*`ROM_AW +: `ROM_AW] = ofs[i];
    end

endmodule

`default_nettype wire

// File: design/rom_sys_top.sv
// Slot ports are flat vectors with slot 0 in the low bits; narrow slots return data in bits 7:0
`timescale 1ns/1ps
`default_nettype none
`include "rom_sys_config.svh"

module rom_sys_top (
    input  wire                           clk,
    input  wire                           rst_n,
    // ROM download
    input  wire                           downloading,
    input  wire  [`DL_AW-1:0]             ioctl_addr,
    input  wire  [7:0]                    ioctl_dout,
    input  wire                           ioctl_wr,
    output wire  [`ROM_AW-1:0]            prog_addr,
    output wire  [7:0]                    prog_data,
    output wire  [1:0]                    prog_mask,
    output wire                           prog_we,
    // SDRAM read port, sdram_ack is shared with the prog writes
    output wire                           sdram_req,
    output wire  [`ROM_AW-1:0]            sdram_addr,
    input  wire                           sdram_ack,
    input  wire                           data_rdy,
    input  wire  [15:0]                   data_read,
    // Read slots
    input  wire  [`NSLOTS-1:0]            slot_cs,
    input  wire  [`NSLOTS*`SLOT_AW-1:0]   slot_addr,
    output wire  [`NSLOTS*16-1:0]         slot_dout,
    output wire  [`NSLOTS-1:0]            slot_ok,
    // AXI4-Lite
    input  wire  [`AXI_AW-1:0]            awaddr,
    input  wire                           awvalid,
    output wire                           awready,
    input  wire  [31:0]                   wdata,
    input  wire  [3:0]                    wstrb,
    input  wire                           wvalid,
    output wire                           wready,
    output rom_sys_pkg::axi_resp_t        bresp,
    output wire                           bvalid,
    input  wire                           bready,
    input  wire  [`AXI_AW-1:0]            araddr,
    input  wire                           arvalid,
    output wire                           arready,
    output wire  [31:0]                   rdata,
    output rom_sys_pkg::axi_resp_t        rresp,
    output wire                           rvalid,
    input  wire                           rready
);

    wire [7:0]                 game_cfg;
    wire                       hdr_valid;
    wire [`NSLOTS-1:0]         slot_en;
    wire [`NSLOTS*`ROM_AW-1:0] slot_ofs;

    rom_dl_writer u_writer (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .ioctl_wr    ( ioctl_wr    ),
        .sdram_ack   ( sdram_ack   ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_we     ( prog_we     ),
        .game_cfg    ( game_cfg    ),
        .hdr_valid   ( hdr_valid   )
    );

    rom_slot_arb u_arb (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .slot_en     ( slot_en     ),
        .slot_ofs    ( slot_ofs    ),
        .slot_cs     ( slot_cs     ),
        .slot_addr   ( slot_addr   ),
        .slot_dout   ( slot_dout   ),
        .slot_ok     ( slot_ok     ),
        .sdram_req   ( sdram_req   ),
        .sdram_addr  ( sdram_addr  ),
        .sdram_ack   ( sdram_ack   ),
        .data_rdy    ( data_rdy    ),
        .data_read   ( data_read   )
    );

    rom_cfg_regs u_regs (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .awaddr      ( awaddr      ),
        .awvalid     ( awvalid     ),
        .awready     ( awready     ),
        .wdata       ( wdata       ),
        .wstrb       ( wstrb       ),
        .wvalid      ( wvalid      ),
        .wready      ( wready      ),
        .bresp       ( bresp       ),
        .bvalid      ( bvalid      ),
        .bready      ( bready      ),
        .araddr      ( araddr      ),
        .arvalid     ( arvalid     ),
        .arready     ( arready     ),
        .rdata       ( rdata       ),
        .rresp       ( rresp       ),
        .rvalid      ( rvalid      ),
        .rready      ( rready      ),
        .downloading ( downloading ),
        .hdr_valid   ( hdr_valid   ),
        .game_cfg    ( game_cfg    ),
        .slot_en     ( slot_en     ),
        .slot_ofs    ( slot_ofs    )
    );

endmodule

`default_nettype wire

// File: verif/rom_sys_chk.sv
// Bound to rom_sys_top; assumes sdram_ack serves prog writes first when both ports wait
`timescale 1ns/1ps
`default_nettype none
`include "rom_sys_config.svh"

module rom_sys_chk (
    input wire                clk,
    input wire                rst_n,
    input wire                downloading,
    input wire                prog_we,
    input wire [`ROM_AW-1:0]  prog_addr,
    input wire                sdram_ack,
    input wire                sdram_req,
    input wire [`ROM_AW-1:0]  sdram_addr,
    input wire                data_rdy,
    input wire                awvalid,
    input wire                awready,
    input wire                wvalid,
    input wire                wready,
    input wire                bvalid,
    input wire                bready,
    input wire                arvalid,
    input wire                arready,
    input wire                rvalid,
    input wire                rready
);

    logic rd_pend;      // Read acked, data not back yet

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            rd_pend <= 1'b0;
        else if (data_rdy)
            rd_pend <= 1'b0;
        else if (sdram_req && sdram_ack)
            rd_pend <= 1'b1;
    end

    a_prog_hold: assert property (@(posedge clk) disable iff (!rst_n)
        prog_we && !sdram_ack |=> prog_we && $stable(prog_addr))
        else $error("prog_we or prog_addr changed before sdram_ack");

    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        sdram_req && !sdram_ack |=> sdram_req && $stable(sdram_addr))
        else $error("sdram_req or sdram_addr changed before sdram_ack");

    a_one_read: assert property (@(posedge clk) disable iff (!rst_n)
        rd_pend |-> !sdram_req)
        else $error("second SDRAM read issued while one is outstanding");

    a_no_read_dl: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(sdram_req) |-> !$past(downloading))
        else $error("SDRAM read started during download");

    a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid)
        else $error("awvalid dropped before awready");
    a_w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid)
        else $error("wvalid dropped before wready");
    a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid)
        else $error("arvalid dropped before arready");
    a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");
    a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

endmodule

bind rom_sys_top rom_sys_chk chk_i (.*);

`default_nettype wire

// File: verif/rom_sys_tb.sv
// Downloads 256 bytes; slot addresses and offsets stay inside the downloaded words
`timescale 1ns/1ps
`default_nettype none
`include "rom_sys_config.svh"

module rom_sys_tb;

    import rom_sys_pkg::*;

    localparam int DL_BYTES  = 256;
    localparam int ROM_WORDS = (DL_BYTES - `HDR_LEN) / 2;
    localparam int MEM_WORDS = 4096;
    localparam int TMO       = 200;

    logic                        clk, rst_n, downloading, ioctl_wr;
    logic [`DL_AW-1:0]           ioctl_addr;
    logic [7:0]                  ioctl_dout;
    logic                        sdram_ack, data_rdy;
    logic [15:0]                 data_read;
    logic [`NSLOTS-1:0]          slot_cs;
    logic [`NSLOTS*`SLOT_AW-1:0] slot_addr;
    logic [`AXI_AW-1:0]          awaddr, araddr;
    logic                        awvalid, wvalid, bready, arvalid, rready;
    logic [31:0]                 wdata;
    logic [3:0]                  wstrb;
    wire  [`ROM_AW-1:0]          prog_addr, sdram_addr;
    wire  [7:0]                  prog_data;
    wire  [1:0]                  prog_mask;
    wire                         prog_we, sdram_req, awready, wready, bvalid;
    wire                         arready, rvalid;
    wire  [`NSLOTS*16-1:0]       slot_dout;
    wire  [`NSLOTS-1:0]          slot_ok;
    wire  [31:0]                 rdata;
    axi_resp_t                   bresp, rresp;

    logic [15:0]        mem [MEM_WORDS];    // SDRAM model contents
    logic [7:0]         img [DL_BYTES];     // Downloaded bytes past the header
    logic [`ROM_AW-1:0] ofs_sh [`NSLOTS];
    logic [`NSLOTS-1:0] en_sh;
    logic [7:0]         hdr0;
    int                 errors, checks, req_count, wr_count;

    rom_sys_top rom_sys_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    // Slot data as the slot rules give it, built from the downloaded image
    function automatic logic [15:0] expected_slot(input int slot, input logic [`ROM_AW-1:0] ofs,
                                                  input logic [`SLOT_AW-1:0] addr);
        sdram_word_t w;
        int          wa;
        wa = (slot < 2) ? int'(ofs) + int'(addr) : int'(ofs) + int'(addr >> 1);
        w.lane.lo = img[2 * wa];
        w.lane.hi = img[2 * wa + 1];
        if (slot < 2)
            return w.word;
        return {8'h00, addr[0] ? w.lane.hi : w.lane.lo};
    endfunction

    task automatic axi_write(input logic [7:0] a, input logic [31:0] d, input logic [3:0] s,
                             output axi_resp_t resp);
        int n;
        awaddr  = a;
        wdata   = d;
        wstrb   = s;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        for (n = 0; n < TMO && !(awready && wready); n++)
            tick();
        if (!(awready && wready))
            abort_on_timeout("awready and wready");
        tick();                             // Handshake edge
        awvalid = 1'b0;
        wvalid  = 1'b0;
        for (n = 0; n < TMO && !bvalid; n++)
            tick();
        if (!bvalid)
            abort_on_timeout("bvalid");
        resp = bresp;
        tick();
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] a, output logic [31:0] d, output axi_resp_t resp);
        int n;
        araddr  = a;
        arvalid = 1'b1;
        rready  = 1'b1;
        for (n = 0; n < TMO && !arready; n++)
            tick();
        if (!arready)
            abort_on_timeout("arready");
        tick();
        arvalid = 1'b0;
        for (n = 0; n < TMO && !rvalid; n++)
            tick();
        if (!rvalid)
            abort_on_timeout("rvalid");
        d    = rdata;
        resp = rresp;
        tick();
        rready = 1'b0;
    endtask

    task automatic set_ofs(input int s, input logic [`ROM_AW-1:0] v);
        axi_resp_t r;
        axi_write(8'(`REG_OFS0 + 4 * s), 32'(v), 4'hf, r);
        check("offset write response", 32'(r), 32'(OKAY));
        ofs_sh[s] = v;
    endtask

    task automatic set_addr(input int s, input logic [`SLOT_AW-1:0] a);
        slot_addr[s*`SLOT_AW +: `SLOT_AW] = a;
    endtask

    task automatic download();
        int n;
        downloading = 1'b1;
        tick();
        for (int a = 0; a < DL_BYTES; a++) begin
            ioctl_addr = `DL_AW'(a);
            ioctl_dout = 8'($urandom);
            ioctl_wr   = 1'b1;
            if (a >= `HDR_LEN)
                img[a - `HDR_LEN] = ioctl_dout;
            else if (a == 0)
                hdr0 = ioctl_dout;
            tick();
            ioctl_wr = 1'b0;
            if (a >= `HDR_LEN) begin
                for (n = 0; n < TMO; n++) begin
                    @(negedge clk);
                    if (sdram_ack)
                        break;
                end
                if (n == TMO)
                    abort_on_timeout("sdram_ack on a prog write");
            end
            tick();
        end
        downloading = 1'b0;
        tick();
    endtask

    // Waits until every slot in mask shows slot_ok for its current address
    task automatic wait_ok(input logic [`NSLOTS-1:0] mask);
        int n;
        tick();
        for (n = 0; n < TMO; n++) begin
            @(negedge clk);
            if ((slot_ok & mask) == mask)
                break;
        end
        if (n == TMO)
            abort_on_timeout("slot_ok");
        tick();
    endtask

    // SDRAM controller model, prog writes take priority
    initial begin : sdram_model
        logic [`ROM_AW-1:0] ra;
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = 16'(i * 40503) ^ 16'h5a5a;
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            tick();
            sdram_ack = 1'b0;
            data_rdy  = 1'b0;
            if (prog_we) begin
                repeat ($urandom_range(2, 0)) tick();
                if (prog_mask[0])
                    mem[prog_addr[11:0]][7:0] = prog_data;
                if (prog_mask[1])
                    mem[prog_addr[11:0]][15:8] = prog_data;
                wr_count++;
                sdram_ack = 1'b1;
            end else if (sdram_req) begin
                repeat ($urandom_range(2, 0)) tick();
                ra        = sdram_addr;
                sdram_ack = 1'b1;
                tick();
                sdram_ack = 1'b0;
                repeat ($urandom_range(2, 0)) tick();
                data_read = mem[ra[11:0]];
                data_rdy  = 1'b1;
            end
        end
    end

    // Checks each slot_ok against the address and enable the DUT sampled
    initial begin : compare_slots
        logic [`SLOT_AW-1:0] a_q [`NSLOTS];
        logic [`NSLOTS-1:0]  cs_q;
        logic                req_q;
        req_q = 1'b0;
        forever begin
            @(posedge clk);
            cs_q = slot_cs;
            for (int i = 0; i < `NSLOTS; i++)
                a_q[i] = slot_addr[i*`SLOT_AW +: `SLOT_AW];
            @(negedge clk);
            if (sdram_req && !req_q)
                req_count++;
            req_q = sdram_req;
            for (int i = 0; i < `NSLOTS; i++) begin
                if (slot_ok[i] && !(en_sh[i] && cs_q[i]))
                    check($sformatf("slot %0d slot_ok while idle", i), 32'(slot_ok[i]), 0);
                else if (slot_ok[i])
                    check($sformatf("slot %0d data", i), 32'(slot_dout[i*16 +: 16]),
                          32'(expected_slot(i, ofs_sh[i], a_q[i])));
            end
        end
    end

    initial begin : main
        logic [31:0]         d;
        axi_resp_t           r;
        int                  s, c;
        logic [`SLOT_AW-1:0] a;

        void'($urandom(32'hdebf));
        errors      = 0;
        checks      = 0;
        req_count   = 0;
        wr_count    = 0;
        rst_n       = 1'b0;
        downloading = 1'b0;
        ioctl_wr    = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        slot_cs     = '0;
        slot_addr   = '0;
        awaddr      = '0;
        araddr      = '0;
        wdata       = '0;
        wstrb       = '0;
        awvalid     = 1'b0;
        wvalid      = 1'b0;
        bready      = 1'b0;
        arvalid     = 1'b0;
        rready      = 1'b0;
        en_sh       = '0;
        for (int i = 0; i < `NSLOTS; i++)
            ofs_sh[i] = '0;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;
        tick();

        // Register reset values
        for (int k = 0; k < 7; k++) begin
            a = (k < 3) ? `SLOT_AW'(4 * k) : `SLOT_AW'(`REG_OFS0 + 4 * (k - 3));
            axi_read(8'(a), d, r);
            check($sformatf("reset value at %h", a), d, 0);
            check("reset read response", 32'(r), 32'(OKAY));
        end
        axi_read(8'h0c, d, r);
        check("unmapped read response", 32'(r), 32'(SLVERR));

        // Download and header capture
        download();
        check("prog write count", wr_count, DL_BYTES - `HDR_LEN);
        for (int w = 0; w < ROM_WORDS; w++)
            check($sformatf("SDRAM word %0d", w), 32'(mem[w]), {16'h0, img[2*w+1], img[2*w]});
        axi_read(`REG_GAMECFG, d, r);
        check("GAMECFG", d, 32'(hdr0));
        axi_read(`REG_STATUS, d, r);
        check("STATUS after download", d, 32'h2);

        // Read-only STATUS and partial strobes
        axi_write(`REG_STATUS, 32'h3, 4'hf, r);
        check("STATUS write response", 32'(r), 32'(SLVERR));
        axi_read(`REG_STATUS, d, r);
        check("STATUS after write", d, 32'h2);
        axi_read(`REG_CTRL, d, r);
        check("CTRL after STATUS write", d, 0);
        axi_write(`REG_OFS0 + 4, 32'hffffffff, 4'b0001, r);
        check("OFS1 byte 0 write response", 32'(r), 32'(OKAY));
        axi_read(`REG_OFS0 + 4, d, r);
        check("OFS1 byte 0 strobe", d, 32'h0000ff);
        axi_write(`REG_OFS0 + 4, 32'h00aa5500, 4'b0110, r);
        check("OFS1 bytes 1-2 write response", 32'(r), 32'(OKAY));
        axi_read(`REG_OFS0 + 4, d, r);
        check("OFS1 bytes 1-2 strobe", d, 32'h2a55ff);   // Top bits beyond 22 dropped

        // Single slots with random offsets
        for (int i = 0; i < `NSLOTS; i++)
            set_ofs(i, `ROM_AW'($urandom_range(31, 0)));
        axi_write(`REG_CTRL, 32'hf, 4'hf, r);
        check("CTRL write response", 32'(r), 32'(OKAY));
        en_sh = 4'hf;
        for (int k = 0; k < 24; k++) begin
            s = $urandom_range(3, 0);
            a = (s < 2) ? `SLOT_AW'($urandom_range(94, 0)) : `SLOT_AW'($urandom_range(189, 0));
            set_addr(s, a);
            slot_cs = `NSLOTS'(1 << s);
            wait_ok(`NSLOTS'(1 << s));
            c = req_count;
            slot_cs = '0;                   // Drop the select, then ask again
            tick();
            slot_cs = `NSLOTS'(1 << s);
            wait_ok(`NSLOTS'(1 << s));
            check("reads on a cached address", req_count, c);
        end

        // All slots at once
        for (int k = 0; k < 8; k++) begin
            for (int i = 0; i < `NSLOTS; i++)
                set_addr(i, (i < 2) ? `SLOT_AW'($urandom_range(94, 0))
                                    : `SLOT_AW'($urandom_range(189, 0)));
            slot_cs = 4'hf;
            c = req_count;
            wait_ok(4'hf);
            check("grants for four slots", 32'(req_count - c <= 4), 1);
        end

        // Disabled slot stays idle
        slot_cs = '0;
        tick();
        axi_write(`REG_CTRL, 32'h7, 4'hf, r);
        check("CTRL write response", 32'(r), 32'(OKAY));
        en_sh = 4'h7;
        set_addr(3, `SLOT_AW'(ofs_sh[3] < 10 ? 150 : 2));
        slot_cs = 4'b1000;
        c = req_count;
        repeat (20) tick();
        check("slot 3 disabled slot_ok", 32'(slot_ok[3]), 0);
        check("reads for a disabled slot", req_count, c);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+design
design/rom_sys_pkg.sv
design/rom_dl_writer.sv
design/rom_slot_arb.sv
design/rom_cfg_regs.sv
design/rom_sys_top.sv
verif/rom_sys_chk.sv
verif/rom_sys_tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator and run; passes only if the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sim.f --top-module rom_sys_tb -o rom_sys_sim &&
./obj_dir/rom_sys_sim | tee /dev/stderr | grep -q "^TEST RESULT: PASS$" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
